// ==== src.f ====
design/rain_pkg.sv
design/score_pkg.sv
design/frame_timer.sv
design/drop_lfsr.sv
design/sprite_plotter.sv
design/object_positions.sv
design/rain_fsm.sv
design/score_display.sv
design/rain_game.sv
verification/rain_game_sva.sv
verification/rain_game_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rain_game testbench with Verilator.
# The exit status is the simulator's, so a failing run makes the script fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module rain_game_tb -o rain_game_sim \
	&& ./obj_dir/rain_game_sim \
	|| exit 1

// ==== verification/rain_game_tb.sv ====
`timescale 1ns/1ns

module rain_game_tb;
	import rain_pkg::*;
	import score_pkg::*;

	localparam int W = 16;
	localparam int H = 12;
	localparam int NUM_DROPS = 2;
	localparam int FRAME_CYCLES = 600;
	localparam int SCORE_MAX = 20;
	localparam int NUM_ROWS = 24;
	localparam int RESET_ROW = 6;  // Rows played before the mid-game reset
	localparam int PERIOD = 40;
	localparam coord_t X_MAX = coord_t'(W - SPRITE_SIZE);
	localparam coord_t Y_MAX = coord_t'(H - SPRITE_SIZE);
	localparam longint CLEAR_NS = 3 * (W * H + 64) * PERIOD;
	localparam longint WATCHDOG_NS =
		longint'(RESET_ROW + NUM_ROWS + 4) * FRAME_CYCLES * PERIOD + CLEAR_NS;

	// One frame: switches in, expected positions and scores out
	typedef struct packed {
		logic   mv1;
		logic   mv2;
		coord_t p1_x;
		coord_t p2_x;
		score_t s1;
		score_t s2;
	} row_t;

	logic    clk, reset, move_p1, move_p2, plot;
	coord_t  x, y;
	colour_t colour;
	seg_t    hex [8];
	row_t    rows [NUM_ROWS];
	coord_t  qx [$];
	coord_t  qy [$];
	colour_t qc [$];
	colour_t fb [H][W];
	coord_t  drop_x [NUM_DROPS];
	coord_t  drop_y [NUM_DROPS];
	logic    halted;

	rain_game #(
		.SCREEN_W(W), .SCREEN_H(H), .NUM_DROPS(NUM_DROPS),
		.FRAME_CYCLES(FRAME_CYCLES), .SCORE_MAX(SCORE_MAX)
	) dut (
		.clk(clk), .reset(reset), .move_p1(move_p1), .move_p2(move_p2),
		.plot(plot), .x(x), .y(y), .colour(colour),
		.hex0(hex[0]), .hex1(hex[1]), .hex2(hex[2]), .hex3(hex[3]),
		.hex4(hex[4]), .hex5(hex[5]), .hex6(hex[6]), .hex7(hex[7])
	);

	bind sprite_plotter rain_game_sva #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_sva (
		.clk(clk), .reset(reset), .plot(plot), .x(x), .y(y), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Plot stream into a queue and the model frame buffer
	always @(negedge clk) begin
		if (plot === 1'b1) begin
			qx.push_back(x);
			qy.push_back(y);
			qc.push_back(colour);
			if (x < coord_t'(W) && y < coord_t'(H))
				fb[y][x] = colour;
		end
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_coord(input string name, input coord_t exp, input coord_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_colour(input string name, input colour_t exp, input colour_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_score(input string name, input score_t exp, input score_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_seg(input string name, input seg_t exp, input seg_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	// Decimal digits of the score, ones first
	task automatic check_hex(input string name, input score_t s, input int base);
		int v;
		v = int'(s);
		for (int d = 0; d < 4; d++) begin
			check_seg($sformatf("%s digit %0d", name, d), SEG_TABLE[v % 10], hex[base + d]);
			v = v / 10;
		end
	endtask

	task automatic check_scores(input string tag, input score_t s1, input score_t s2);
		check_score({tag, " p1 score"}, s1, dut.u_objects.p1_score);
		check_score({tag, " p2 score"}, s2, dut.u_objects.p2_score);
		check_hex({tag, " p1 hex"}, s1, 0);
		check_hex({tag, " p2 hex"}, s2, 4);
	endtask

	task automatic pop_pixel(output coord_t px, output coord_t py, output colour_t pc);
		while (qx.size() == 0)
			@(posedge clk);
		px = qx.pop_front();
		py = qy.pop_front();
		pc = qc.pop_front();
	endtask

	// Four pixels, row-major, origin taken from the first one
	task automatic take_block(input string name, output coord_t ox, output coord_t oy,
			output colour_t oc);
		coord_t  px, py;
		colour_t pc;
		for (int i = 0; i < SPRITE_SIZE * SPRITE_SIZE; i++) begin
			pop_pixel(px, py, pc);
			if (i == 0) begin
				ox = px;
				oy = py;
				oc = pc;
			end
			check_coord({name, " x"}, ox + coord_t'(i % SPRITE_SIZE), px);
			check_coord({name, " y"}, oy + coord_t'(i / SPRITE_SIZE), py);
			check_colour({name, " colour"}, oc, pc);
		end
	endtask

	task automatic expect_block(input string name, input coord_t ex, input coord_t ey,
			input colour_t ec);
		coord_t  ox, oy;
		colour_t oc;
		take_block(name, ox, oy, oc);
		check_coord({name, " origin x"}, ex, ox);
		check_coord({name, " origin y"}, ey, oy);
		check_colour({name, " block colour"}, ec, oc);
	endtask

	task automatic take_drop_spawn(input int d);
		colour_t c;
		string   name;
		name = $sformatf("drop %0d spawn", d);
		take_block(name, drop_x[d], drop_y[d], c);
		check_colour({name, " block colour"}, COLOUR_DROP, c);
		check_coord({name, " origin y"}, '0, drop_y[d]);
		if (drop_x[d] > X_MAX)
			stop_run($sformatf("Drop %0d spawned off screen at x %0d", d, drop_x[d]));
	endtask

	task automatic take_fill(input string name, input colour_t fc);
		logic    seen [H][W];
		coord_t  px, py;
		colour_t pc;
		foreach (seen[r, c])
			seen[r][c] = 1'b0;
		for (int i = 0; i < W * H; i++) begin
			pop_pixel(px, py, pc);
			check_colour({name, " colour"}, fc, pc);
			if (px >= coord_t'(W) || py >= coord_t'(H) || seen[py][px])
				stop_run($sformatf("The %s plotted (%0d,%0d) off screen or twice", name, px, py));
			seen[py][px] = 1'b1;
		end
		foreach (fb[r, c])
			check_colour($sformatf("%s screen (%0d,%0d)", name, c, r), fc, fb[r][c]);
	endtask

	task automatic move_player(input logic m, inout coord_t px, inout score_t s);
		if (m && px < X_MAX) begin
			px = px + coord_t'(1);
			s = s + score_t'(1);
		end else if (!m && px != '0) begin
			px = px - coord_t'(1);
			s = s + score_t'(1);
		end
	endtask

	task automatic build_table();
		coord_t x1, x2;
		score_t s1, s2;
		logic   m1, m2;
		x1 = coord_t'(W - 3);
		x2 = coord_t'(1);
		s1 = '0;
		s2 = '0;
		for (int k = 0; k < NUM_ROWS; k++) begin
			if (k < 2) begin  // Push both players into their walls
				m1 = 1'b1;
				m2 = 1'b0;
			end else if (k < 11) begin
				m1 = 1'b0;
				m2 = k == 10;
			end else begin
				m1 = ($urandom() % 2) != 0;
				m2 = ($urandom() % 2) != 0;
				if (x1 == '0)
					m1 = 1'b1;  // Player 1 scores every filler frame
				else if (x1 == X_MAX)
					m1 = 1'b0;
			end
			if (s1 < score_t'(SCORE_MAX)) begin
				move_player(m1, x1, s1);
				if (s1 < score_t'(SCORE_MAX))
					move_player(m2, x2, s2);
			end
			rows[k] = '{mv1: m1, mv2: m2, p1_x: x1, p2_x: x2, s1: s1, s2: s2};
		end
	endtask

	task automatic power_on();
		@(negedge clk);
		reset = 1'b1;
		move_p1 = 1'b0;
		move_p2 = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		qx.delete();
		qy.delete();
		qc.delete();
		halted = 1'b0;
		take_fill("clear", COLOUR_BLACK);
		@(negedge clk);
		check_scores("after reset", '0, '0);
		expect_block("p1 first draw", coord_t'(W - 3), Y_MAX, COLOUR_P1);
		expect_block("p2 first draw", coord_t'(1), Y_MAX, COLOUR_P2);
		for (int d = 0; d < NUM_DROPS; d++)
			take_drop_spawn(d);
	endtask

	task automatic play_row(input int k);
		coord_t old1, old2;
		string  tag;
		tag = $sformatf("row %0d", k);
		old1 = k == 0 ? coord_t'(W - 3) : rows[k - 1].p1_x;
		old2 = k == 0 ? coord_t'(1) : rows[k - 1].p2_x;
		@(negedge clk);
		move_p1 = rows[k].mv1;
		move_p2 = rows[k].mv2;
		if (halted) begin
			repeat (FRAME_CYCLES) @(negedge clk);
			if (qx.size() != 0)
				stop_run($sformatf("Pixels plotted after the win fill in %s", tag));
		end else begin
			expect_block({tag, " p1 erase"}, old1, Y_MAX, COLOUR_BLACK);
			if (rows[k].s1 >= score_t'(SCORE_MAX)) begin
				take_fill("win fill", COLOUR_P1);  // Winning step ends the frame
				halted = 1'b1;
			end else begin
				expect_block({tag, " p1 draw"}, rows[k].p1_x, Y_MAX, COLOUR_P1);
				expect_block({tag, " p2 erase"}, old2, Y_MAX, COLOUR_BLACK);
				expect_block({tag, " p2 draw"}, rows[k].p2_x, Y_MAX, COLOUR_P2);
				for (int d = 0; d < NUM_DROPS; d++) begin
					expect_block($sformatf("%s drop %0d erase", tag, d), drop_x[d], drop_y[d],
						COLOUR_BLACK);
					if (drop_y[d] == Y_MAX) begin
						take_drop_spawn(d);  // Bottom row reached
					end else begin
						drop_y[d] = drop_y[d] + coord_t'(1);
						expect_block($sformatf("%s drop %0d draw", tag, d), drop_x[d],
							drop_y[d], COLOUR_DROP);
					end
				end
			end
			@(negedge clk);
		end
		check_scores(tag, rows[k].s1, rows[k].s2);
	endtask

	initial begin
		#(WATCHDOG_NS);
		stop_run("Watchdog expired before the game finished");
	end

	initial begin
		reset = 1'b1;
		move_p1 = 1'b0;
		move_p2 = 1'b0;
		halted = 1'b0;
		void'($urandom(18963));
		build_table();
		power_on();
		for (int k = 0; k < RESET_ROW; k++)
			play_row(k);
		power_on();  // Mid-game reset restarts the whole table
		for (int k = 0; k < NUM_ROWS; k++)
			play_row(k);
		if (!halted) begin
			stop_run("Player 1 never reached the score limit");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// ==== verification/rain_game_sva.sv ====
`timescale 1ns/1ns

module rain_game_sva #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input logic             clk,
	input logic             reset,
	input logic             plot,
	input rain_pkg::coord_t x,
	input rain_pkg::coord_t y,
	input logic             done
);
	import rain_pkg::*;

	// Every plotted pixel lands on the screen
	plot_in_screen: assert property (@(posedge clk) disable iff (reset)
		plot |-> (x < coord_t'(SCREEN_W) && y < coord_t'(SCREEN_H)))
		else $error("plot outside the screen at (%0d,%0d)", x, y);

	done_apart_from_plot: assert property (@(posedge clk) disable iff (reset)
		!(done && plot))
		else $error("done and plot high in the same cycle");

	quiet_in_reset: assert property (@(posedge clk) reset |=> !plot)
		else $error("plot high right after a reset cycle");  // Plotter held quiet

endmodule

// ==== design/rain_game.sv ====
`timescale 1ns/1ns

module rain_game #(
	parameter int SCREEN_W     = 160,
	parameter int SCREEN_H     = 120,
	parameter int NUM_DROPS    = 3,
	parameter int FRAME_CYCLES = 833333,
	parameter int SCORE_MAX    = 999
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              move_p1,
	input  logic              move_p2,
	output logic              plot,
	output rain_pkg::coord_t  x,
	output rain_pkg::coord_t  y,
	output rain_pkg::colour_t colour,
	output score_pkg::seg_t   hex0,
	output score_pkg::seg_t   hex1,
	output score_pkg::seg_t   hex2,
	output score_pkg::seg_t   hex3,
	output score_pkg::seg_t   hex4,
	output score_pkg::seg_t   hex5,
	output score_pkg::seg_t   hex6,
	output score_pkg::seg_t   hex7
);
	import rain_pkg::*;
	import score_pkg::*;

	logic     tick, done;
	logic     start_block, start_fill;
	logic     init, step, spawn;
	logic     p1_win, p2_win;
	obj_sel_t sel;
	coord_t   spawn_x, origin_x, origin_y;
	score_t   p1_score, p2_score;

	frame_timer #(.FRAME_CYCLES(FRAME_CYCLES)) u_timer (
		.clk(clk), .reset(reset), .tick(tick)
	);

	drop_lfsr #(.SCREEN_W(SCREEN_W)) u_lfsr (
		.clk(clk), .reset(reset), .spawn_x(spawn_x)
	);

	sprite_plotter #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_plotter (
		.clk(clk), .reset(reset),
		.start_block(start_block), .start_fill(start_fill),
		.origin_x(origin_x), .origin_y(origin_y),
		.plot(plot), .x(x), .y(y), .done(done)
	);

	object_positions #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
		.NUM_DROPS(NUM_DROPS), .SCORE_MAX(SCORE_MAX)
	) u_objects (
		.clk(clk), .reset(reset), .init(init), .step(step), .spawn(spawn),
		.sel(sel), .move_p1(move_p1), .move_p2(move_p2), .spawn_x(spawn_x),
		.origin_x(origin_x), .origin_y(origin_y),
		.p1_score(p1_score), .p2_score(p2_score),
		.p1_win(p1_win), .p2_win(p2_win)
	);

	rain_fsm #(.NUM_DROPS(NUM_DROPS)) u_fsm (
		.clk(clk), .reset(reset), .tick(tick), .done(done),
		.p1_win(p1_win), .p2_win(p2_win),
		.start_block(start_block), .start_fill(start_fill),
		.init(init), .step(step), .spawn(spawn), .sel(sel), .colour(colour)
	);

	// Player 1 on hex0-3, player 2 on hex4-7
	score_display u_p1_hex (
		.score(p1_score),
		.hex_ones(hex0), .hex_tens(hex1), .hex_hundreds(hex2), .hex_thousands(hex3)
	);

	score_display u_p2_hex (
		.score(p2_score),
		.hex_ones(hex4), .hex_tens(hex5), .hex_hundreds(hex6), .hex_thousands(hex7)
	);

endmodule

// ==== design/score_display.sv ====
`timescale 1ns/1ns

module score_display (
	input  score_pkg::score_t score,
	output score_pkg::seg_t   hex_ones,
	output score_pkg::seg_t   hex_tens,
	output score_pkg::seg_t   hex_hundreds,
	output score_pkg::seg_t   hex_thousands
);
	import score_pkg::*;

	logic [15:0] bcd;
	digit_t ones, tens, hundreds, thousands;

	// Shift-add-3, one input bit per pass
	always_comb begin
		bcd = '0;
		for (int i = $bits(score_t) - 1; i >= 0; i--) begin
			for (int d = 0; d < 4; d++) begin
				if (bcd[4*d +: 4] >= 4'd5)
					bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
			end
			bcd = {bcd[14:0], score[i]};
		end
	end

	assign ones = bcd[3:0];
	assign tens = bcd[7:4];
	assign hundreds = bcd[11:8];
	assign thousands = bcd[15:12];

	assign hex_ones = SEG_TABLE[ones];
	assign hex_tens = SEG_TABLE[tens];
	assign hex_hundreds = SEG_TABLE[hundreds];
	assign hex_thousands = SEG_TABLE[thousands];  // Never above 1 for 10 bits

endmodule

// ==== design/rain_fsm.sv ====
`timescale 1ns/1ns

module rain_fsm #(
	parameter int NUM_DROPS = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               tick,
	input  logic               done,
	input  logic               p1_win,
	input  logic               p2_win,
	output logic               start_block,
	output logic               start_fill,
	output logic               init,
	output logic               step,
	output logic               spawn,
	output rain_pkg::obj_sel_t sel,
	output rain_pkg::colour_t  colour
);
	import rain_pkg::*;

	localparam obj_sel_t LAST_OBJ = obj_sel_t'(NUM_DROPS + 1);

	typedef enum logic [3:0] {
		S_BOOT,
		S_CLEAR,
		S_SPAWN,
		S_DRAW,
		S_IDLE,
		S_ERASE,
		S_STEP,
		S_WIN,
		S_HALT
	} state_t;

	state_t   state;
	obj_sel_t obj;
	logic     issued;  // Action of this state already launched
	logic     power_on;
	logic     p2_won;

	assign sel = obj;
	assign init = state == S_CLEAR && !issued;
	assign start_fill = (state == S_CLEAR || state == S_WIN) && !issued;
	assign start_block = (state == S_DRAW || state == S_ERASE) && !issued;
	assign step = state == S_STEP && !issued;
	assign spawn = state == S_SPAWN;

	always_comb begin
		case (state)
			S_DRAW: begin
				if (obj == OBJ_P1)
					colour = COLOUR_P1;
				else if (obj == OBJ_P2)
					colour = COLOUR_P2;
				else
					colour = COLOUR_DROP;
			end
			S_WIN, S_HALT: colour = p2_won ? COLOUR_P2 : COLOUR_P1;
			default: colour = COLOUR_BLACK;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_BOOT;
			obj <= '0;
			issued <= 1'b0;
			power_on <= 1'b0;
			p2_won <= 1'b0;
		end else begin
			issued <= 1'b1;
			case (state)
				S_BOOT: begin
					state <= S_CLEAR;
					issued <= 1'b0;
				end
				S_CLEAR: if (done) begin
					state <= S_DRAW;
					issued <= 1'b0;
					obj <= '0;
					power_on <= 1'b1;
				end
				S_SPAWN: begin
					state <= S_DRAW;
					issued <= 1'b0;
				end
				S_DRAW: if (done) begin
					issued <= 1'b0;
					if (obj == LAST_OBJ) begin
						state <= S_IDLE;
						power_on <= 1'b0;
					end else begin
						obj <= obj + 1'b1;
						if (!power_on)
							state <= S_ERASE;
						else if (obj != OBJ_P1)
							state <= S_SPAWN;  // Next one is a drop
						else
							state <= S_DRAW;
					end
				end
				S_IDLE: if (tick) begin
					state <= S_ERASE;
					issued <= 1'b0;
					obj <= '0;
				end
				S_ERASE: if (done) begin
					state <= S_STEP;
					issued <= 1'b0;
				end
				// Win flags follow the score one cycle after the step
				S_STEP: if (issued) begin
					issued <= 1'b0;
					if (obj == OBJ_P1 && p1_win) begin
						state <= S_WIN;
						p2_won <= 1'b0;
					end else if (obj == OBJ_P2 && p2_win) begin
						state <= S_WIN;
						p2_won <= 1'b1;
					end else begin
						state <= S_DRAW;
					end
				end
				S_WIN: if (done) state <= S_HALT;
				S_HALT: state <= S_HALT;  // Game over until reset
				default: state <= S_BOOT;
			endcase
		end
	end

endmodule

// ==== design/object_positions.sv ====
`timescale 1ns/1ns

module object_positions #(
	parameter int SCREEN_W  = 160,
	parameter int SCREEN_H  = 120,
	parameter int NUM_DROPS = 3,
	parameter int SCORE_MAX = 999
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               init,
	input  logic               step,
	input  logic               spawn,
	input  rain_pkg::obj_sel_t sel,
	input  logic               move_p1,
	input  logic               move_p2,
	input  rain_pkg::coord_t   spawn_x,
	output rain_pkg::coord_t   origin_x,
	output rain_pkg::coord_t   origin_y,
	output score_pkg::score_t  p1_score,
	output score_pkg::score_t  p2_score,
	output logic               p1_win,
	output logic               p2_win
);
	import rain_pkg::*;
	import score_pkg::*;

	localparam coord_t X_MAX = coord_t'(SCREEN_W - SPRITE_SIZE);
	localparam coord_t Y_MAX = coord_t'(SCREEN_H - SPRITE_SIZE);

	coord_t p1_x, p2_x;
	coord_t drop_x [NUM_DROPS];
	coord_t drop_y [NUM_DROPS];
	logic   p1_moves, p2_moves;

	// A move only happens away from the edge the switch points at
	assign p1_moves = step && sel == OBJ_P1 && (move_p1 ? p1_x < X_MAX : p1_x != '0);
	assign p2_moves = step && sel == OBJ_P2 && (move_p2 ? p2_x < X_MAX : p2_x != '0);

	always_ff @(posedge clk) begin
		if (reset || init) begin
			p1_score <= '0;
			p2_score <= '0;
		end else begin
			if (p1_moves)
				p1_score <= p1_score + 1'b1;  // One point per pixel moved
			if (p2_moves)
				p2_score <= p2_score + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (init) begin
			p1_x <= coord_t'(SCREEN_W - 3);
			p2_x <= coord_t'(1);
		end else begin
			if (p1_moves)
				p1_x <= move_p1 ? p1_x + 1'b1 : p1_x - 1'b1;
			if (p2_moves)
				p2_x <= move_p2 ? p2_x + 1'b1 : p2_x - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_DROPS; i++) begin
			if (sel == obj_sel_t'(i + 2)) begin
				if (spawn || (step && drop_y[i] == Y_MAX)) begin
					drop_x[i] <= spawn_x;  // Back to the top row
					drop_y[i] <= '0;
				end else if (step) begin
					drop_y[i] <= drop_y[i] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		origin_x = p1_x;
		origin_y = Y_MAX;  // Players live on the bottom row
		if (sel == OBJ_P2)
			origin_x = p2_x;
		for (int i = 0; i < NUM_DROPS; i++) begin
			if (sel == obj_sel_t'(i + 2)) begin
				origin_x = drop_x[i];
				origin_y = drop_y[i];
			end
		end
	end

	assign p1_win = p1_score >= score_t'(SCORE_MAX);
	assign p2_win = p2_score >= score_t'(SCORE_MAX);

endmodule

// ==== design/sprite_plotter.sv ====
`timescale 1ns/1ns

module sprite_plotter #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start_block,
	input  logic             start_fill,
	input  rain_pkg::coord_t origin_x,
	input  rain_pkg::coord_t origin_y,
	output logic             plot,
	output rain_pkg::coord_t x,
	output rain_pkg::coord_t y,
	output logic             done
);
	import rain_pkg::*;

	logic   active;
	logic   fill_mode;
	coord_t cnt_x, cnt_y;
	coord_t base_x, base_y;
	coord_t lim_x, lim_y;
	logic   last;

	assign lim_x = fill_mode ? coord_t'(SCREEN_W - 1) : coord_t'(SPRITE_SIZE - 1);
	assign lim_y = fill_mode ? coord_t'(SCREEN_H - 1) : coord_t'(SPRITE_SIZE - 1);
	assign last = (cnt_x == lim_x) && (cnt_y == lim_y);

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			fill_mode <= 1'b0;
			cnt_x <= '0;
			cnt_y <= '0;
			done <= 1'b0;
		end else begin
			done <= active && last;
			if (start_block || start_fill) begin
				active <= 1'b1;
				fill_mode <= start_fill;
				cnt_x <= '0;
				cnt_y <= '0;
			end else if (active) begin
				if (cnt_x == lim_x) begin  // Row-major walk
					cnt_x <= '0;
					if (last)
						active <= 1'b0;
					else
						cnt_y <= cnt_y + 1'b1;
				end else begin
					cnt_x <= cnt_x + 1'b1;
				end
			end
		end
	end

	// Origin latched on the start strobe, fill always from the corner
	always_ff @(posedge clk) begin
		if (start_fill) begin
			base_x <= '0;
			base_y <= '0;
		end else if (start_block) begin
			base_x <= origin_x;
			base_y <= origin_y;
		end
	end

	assign plot = active;
	assign x = base_x + cnt_x;
	assign y = base_y + cnt_y;

endmodule

// ==== design/drop_lfsr.sv ====
`timescale 1ns/1ns

module drop_lfsr #(
	parameter int SCREEN_W = 160
) (
	input  logic             clk,
	input  logic             reset,
	output rain_pkg::coord_t spawn_x
);
	import rain_pkg::*;

	// Number of legal left edges for a sprite
	localparam int SPAN = SCREEN_W - SPRITE_SIZE + 1;
	localparam int FOLDS = 512 / SPAN;

	logic [8:0] lfsr;
	logic [8:0] folded;

	// x^9 + x^5 + 1, maximal length so zero is never reached
	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= 9'd1;
		else
			lfsr <= {lfsr[7:0], lfsr[8] ^ lfsr[4]};
	end

	always_comb begin
		folded = lfsr;
		for (int i = 0; i < FOLDS; i++)
			if (folded >= 9'(SPAN))
				folded = folded - 9'(SPAN);
	end

	assign spawn_x = coord_t'(folded);

endmodule

// ==== design/frame_timer.sv ====
`timescale 1ns/1ns

module frame_timer #(
	parameter int FRAME_CYCLES = 833333
) (
	input  logic clk,
	input  logic reset,
	output logic tick
);
	localparam int CW = $clog2(FRAME_CYCLES + 1);
	localparam logic [CW-1:0] RELOAD = CW'(FRAME_CYCLES - 1);

	logic [CW-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= RELOAD;
			tick <= 1'b0;
		end else if (count == '0) begin
			count <= RELOAD;  // One tick per FRAME_CYCLES clocks
			tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// ==== design/score_pkg.sv ====
package score_pkg;

	typedef logic [9:0] score_t;
	typedef logic [3:0] digit_t;

	// Active low, bit 0 is segment a
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_TABLE [0:9] = '{
		7'b1000000,  // 0
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,  // 5
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0011000   // 9
	};

endpackage

// ==== design/rain_pkg.sv ====
package rain_pkg;

	// Screen coordinate, wide enough for a 160x120 frame
	typedef logic [7:0] coord_t;

	// One bit each of red, green, blue
	typedef logic [2:0] colour_t;

	// 0 is player 1, 1 is player 2, drops from 2 up
	typedef logic [3:0] obj_sel_t;

	localparam colour_t COLOUR_BLACK = 3'b000;  // Erase
	localparam colour_t COLOUR_P1    = 3'b010;  // Green
	localparam colour_t COLOUR_P2    = 3'b100;  // Red
	localparam colour_t COLOUR_DROP  = 3'b001;  // Blue

	// Side of every square sprite
	localparam int SPRITE_SIZE = 2;

	localparam obj_sel_t OBJ_P1 = 4'd0;
	localparam obj_sel_t OBJ_P2 = 4'd1;

endpackage
